/* common/fir_settings.svh */
// FIR filter settings

`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// Sample and coefficient widths in bits
`define FIR_DATA_WIDTH 16
`define FIR_TAP_WIDTH 16

// Number of coefficient slots, and the index width that addresses them
`define FIR_MAX_N_TAPS 8
`define FIR_TAP_ADDR_WIDTH $clog2(`FIR_MAX_N_TAPS)

// Coefficients are fixed point with this many fraction bits
`define FIR_TAP_FRAC 15

// Product width plus three guard bits for the running sum
`define FIR_ACC_WIDTH (`FIR_DATA_WIDTH + `FIR_TAP_WIDTH + 3)

// Only these AXI4-Lite address bits take part in register decoding
`define FIR_ADDR_MASK 32'h0000_00FF

`endif

/* common/fir_pkg.sv */
// FIR filter shared types

package fir_pkg;

    `include "fir_settings.svh"

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Master to slave half of the AXI4-Lite bus
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Slave to master half of the AXI4-Lite bus
    typedef struct packed {
        logic        awready;
        logic        wready;
        axil_resp_e  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        axil_resp_e  rresp;
        logic        rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic signed [`FIR_DATA_WIDTH-1:0] data;
        logic                              valid;
    } stream_beat_t;

    // Register map as word index of the masked byte address
    typedef enum logic [5:0] {
        REG_N_TAPS   = 6'd0,
        REG_TAP_DATA = 6'd1,
        REG_TAP_ADDR = 6'd2
    } cfg_reg_e;

    typedef enum logic [1:0] {
        IDLE,
        MAC,
        EMIT
    } fir_state_e;

endpackage

/* rtl/axil_register_cu.sv */
// AXI4-Lite configuration registers

`include "fir_settings.svh"

module axil_register_cu
    import fir_pkg::*;
(
    input  logic                            clock,
    input  logic                            arst_n,
    input  axil_req_t                       axil_req,
    output axil_rsp_t                       axil_rsp,
    output logic [31:0]                     n_taps,
    output logic [`FIR_TAP_WIDTH-1:0]       tap_data,
    output logic [`FIR_TAP_ADDR_WIDTH-1:0]  tap_addr,
    output logic                            tap_write
);

    localparam int TAP_WIDTH = `FIR_TAP_WIDTH;
    localparam int TAP_ADDR_WIDTH = `FIR_TAP_ADDR_WIDTH;

    logic [31:0] n_taps_q;
    logic [31:0] tap_data_q;
    logic [31:0] tap_addr_q;

    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;

    logic        wr_accept;
    logic        rd_accept;
    cfg_reg_e    wr_reg;
    cfg_reg_e    rd_reg;
    logic [31:0] wr_addr;
    logic [31:0] rd_addr;

    // Merge new write data into a register one byte lane at a time
    function automatic logic [31:0] apply_strobe(
        input logic [31:0] old_value,
        input logic [31:0] new_value,
        input logic [3:0]  strobe
    );
        logic [31:0] merged;
        merged = old_value;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                merged[8*i +: 8] = new_value[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // Address and data are taken together, and only once the last response has gone
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_accept = axil_req.arvalid && !rvalid_q;

    assign wr_addr = axil_req.awaddr & `FIR_ADDR_MASK;
    assign rd_addr = axil_req.araddr & `FIR_ADDR_MASK;
    assign wr_reg  = cfg_reg_e'(wr_addr[7:2]);
    assign rd_reg  = cfg_reg_e'(rd_addr[7:2]);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            n_taps_q   <= 32'd1;
            tap_data_q <= '0;
            tap_addr_q <= '0;
            tap_write  <= 1'b0;
            bvalid_q   <= 1'b0;
        end else begin
            tap_write <= 1'b0;
            if (wr_accept) begin
                bvalid_q <= 1'b1;
                // Unmapped words take the write and drop it
                case (wr_reg)
                    REG_N_TAPS: begin
                        n_taps_q <= apply_strobe(n_taps_q, axil_req.wdata, axil_req.wstrb);
                    end
                    REG_TAP_DATA: begin
                        tap_data_q <= apply_strobe(tap_data_q, axil_req.wdata,
                                                   axil_req.wstrb);
                    end
                    REG_TAP_ADDR: begin
                        tap_addr_q <= apply_strobe(tap_addr_q, axil_req.wdata,
                                                   axil_req.wstrb);
                        tap_write  <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end else if (bvalid_q && axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rvalid_q <= 1'b0;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
        end else if (rvalid_q && axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_accept) begin
            case (rd_reg)
                REG_N_TAPS:   rdata_q <= n_taps_q;
                REG_TAP_DATA: rdata_q <= tap_data_q;
                REG_TAP_ADDR: rdata_q <= tap_addr_q;
                default:      rdata_q <= '0;
            endcase
        end
    end

    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bresp   = OKAY;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.arready = rd_accept;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = OKAY;
        axil_rsp.rvalid  = rvalid_q;
    end

    assign n_taps   = n_taps_q;
    assign tap_data = tap_data_q[TAP_WIDTH-1:0];
    assign tap_addr = tap_addr_q[TAP_ADDR_WIDTH-1:0];

endmodule

/* fir/fir_tap_memory.sv */
// FIR coefficient memory

`include "fir_settings.svh"

module fir_tap_memory (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                tap_write,
    input  logic [`FIR_TAP_ADDR_WIDTH-1:0]      tap_addr,
    input  logic [`FIR_TAP_WIDTH-1:0]           tap_data,
    input  logic [`FIR_TAP_ADDR_WIDTH-1:0]      rd_index,
    output logic signed [`FIR_TAP_WIDTH-1:0]    rd_tap
);

    localparam int TAP_WIDTH = `FIR_TAP_WIDTH;
    localparam int MAX_N_TAPS = `FIR_MAX_N_TAPS;

    logic signed [TAP_WIDTH-1:0] taps [MAX_N_TAPS];

    // The register unit pulses tap_write once its address register holds the new slot
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MAX_N_TAPS; i++) begin
                taps[i] <= '0;
            end
        end else if (tap_write) begin
            taps[tap_addr] <= signed'(tap_data);
        end
    end

    // Combinational read so the MAC sees the coefficient in the same cycle as its index
    assign rd_tap = taps[rd_index];

endmodule

/* fir/fir_filter_serial.sv */
// Serial FIR multiply-accumulate core

`include "fir_settings.svh"

module fir_filter_serial
    import fir_pkg::*;
(
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic [31:0]                         n_taps,
    input  stream_beat_t                        in_beat,
    output logic                                in_ready,
    output stream_beat_t                        out_beat,
    input  logic                                out_ready,
    output logic [`FIR_TAP_ADDR_WIDTH-1:0]      rd_index,
    input  logic signed [`FIR_TAP_WIDTH-1:0]    rd_tap
);

    localparam int DATA_WIDTH = `FIR_DATA_WIDTH;
    localparam int TAP_WIDTH = `FIR_TAP_WIDTH;
    localparam int ACC_WIDTH = `FIR_ACC_WIDTH;
    localparam int MAX_N_TAPS = `FIR_MAX_N_TAPS;
    localparam int TAP_ADDR_WIDTH = `FIR_TAP_ADDR_WIDTH;
    localparam int TAP_FRAC = `FIR_TAP_FRAC;
    localparam int PROD_WIDTH = DATA_WIDTH + TAP_WIDTH;

    fir_state_e state;

    logic signed [DATA_WIDTH-1:0] delay_line [MAX_N_TAPS];
    logic signed [ACC_WIDTH-1:0]  acc;
    logic signed [ACC_WIDTH-1:0]  acc_scaled;
    logic signed [PROD_WIDTH-1:0] product;

    logic [TAP_ADDR_WIDTH-1:0] tap_idx;
    logic [TAP_ADDR_WIDTH:0]   eff_taps;
    logic [TAP_ADDR_WIDTH-1:0] last_idx;

    logic in_xfer;
    logic out_xfer;

    // Zero taps behaves as one, and anything past the memory depth uses all slots
    always_comb begin
        if (n_taps == 32'd0) begin
            eff_taps = (TAP_ADDR_WIDTH + 1)'(1);
        end else if (n_taps > MAX_N_TAPS) begin
            eff_taps = (TAP_ADDR_WIDTH + 1)'(MAX_N_TAPS);
        end else begin
            eff_taps = n_taps[TAP_ADDR_WIDTH:0];
        end
    end

    assign last_idx = TAP_ADDR_WIDTH'(eff_taps - 1'b1);

    assign in_ready = (state == IDLE);
    assign in_xfer  = in_ready && in_beat.valid;
    assign out_xfer = (state == EMIT) && out_ready;

    assign rd_index = tap_idx;
    assign product  = rd_tap * delay_line[tap_idx];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            tap_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_xfer) begin
                        tap_idx <= '0;
                        state   <= MAC;
                    end
                end
                MAC: begin
                    tap_idx <= tap_idx + 1'b1;
                    if (tap_idx == last_idx) begin
                        state <= EMIT;
                    end
                end
                EMIT: begin
                    if (out_xfer) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // New samples enter at position 0 and the oldest one falls off the end
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MAX_N_TAPS; i++) begin
                delay_line[i] <= '0;
            end
        end else if (in_xfer) begin
            delay_line[0] <= in_beat.data;
            for (int i = 1; i < MAX_N_TAPS; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_xfer) begin
            acc <= '0;
        end else if (state == MAC) begin
            acc <= acc + ACC_WIDTH'(product);
        end
    end

    // Drop the coefficient fraction bits, then keep the low sample bits with wrap
    assign acc_scaled = acc >>> TAP_FRAC;

    always_comb begin
        out_beat.data  = acc_scaled[DATA_WIDTH-1:0];
        out_beat.valid = (state == EMIT);
    end

endmodule

/* rtl/fir_filter.sv */
// Configurable FIR filter top

`include "fir_settings.svh"

module fir_filter
    import fir_pkg::*;
(
    input  logic            clock,
    input  logic            arst_n,
    input  axil_req_t       cfg_req,
    output axil_rsp_t       cfg_rsp,
    input  stream_beat_t    in_beat,
    output logic            in_ready,
    output stream_beat_t    out_beat,
    input  logic            out_ready
);

    logic [31:0]                        n_taps;
    logic [`FIR_TAP_WIDTH-1:0]          tap_data;
    logic [`FIR_TAP_ADDR_WIDTH-1:0]     tap_addr;
    logic                               tap_write;
    logic [`FIR_TAP_ADDR_WIDTH-1:0]     rd_index;
    logic signed [`FIR_TAP_WIDTH-1:0]   rd_tap;

    axil_register_cu cu_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .axil_req  (cfg_req),
        .axil_rsp  (cfg_rsp),
        .n_taps    (n_taps),
        .tap_data  (tap_data),
        .tap_addr  (tap_addr),
        .tap_write (tap_write)
    );

    fir_tap_memory tap_memory_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .tap_write (tap_write),
        .tap_addr  (tap_addr),
        .tap_data  (tap_data),
        .rd_index  (rd_index),
        .rd_tap    (rd_tap)
    );

    // The core reads coefficients through the memory read port one tap per cycle
    fir_filter_serial core_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .n_taps    (n_taps),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_ready (out_ready),
        .rd_index  (rd_index),
        .rd_tap    (rd_tap)
    );

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset

module tb_clock_gen (
    output logic clock,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Reset stays low for the first two rising edges
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;
    end

endmodule

/* test/fir_filter_tb.sv */
// FIR filter testbench

`include "fir_settings.svh"

module fir_filter_tb
    import fir_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_WIDTH = `FIR_DATA_WIDTH;
    localparam int TAP_WIDTH = `FIR_TAP_WIDTH;
    localparam int MAX_N_TAPS = `FIR_MAX_N_TAPS;
    localparam int TAP_FRAC = `FIR_TAP_FRAC;
    localparam int TIMEOUT_CYCLES = 2000;
    // Full scale 2**15 does not fit a signed 16-bit sample, so the impulse is its negative
    localparam logic signed [DATA_WIDTH-1:0] IMPULSE = -(2 ** TAP_FRAC);

    logic         clock;
    logic         arst_n;
    axil_req_t    cfg_req;
    axil_rsp_t    cfg_rsp;
    stream_beat_t in_beat;
    logic         in_ready;
    stream_beat_t out_beat;
    logic         out_ready;

    int seed;
    int error_count;
    int test_errors;
    int test_count;
    int failed_tests;
    int sent_count;
    int received_count;
    stream_beat_t expected_q[$];
    stream_beat_t expected_beat;

    logic [31:0] model_n_taps;
    logic [31:0] model_tap_data;
    logic signed [TAP_WIDTH-1:0]  model_taps [MAX_N_TAPS];
    logic signed [DATA_WIDTH-1:0] model_delay [MAX_N_TAPS];

    logic         bp_enable;
    logic [511:0] ready_pattern;
    logic [8:0]   bp_cycle;

    tb_clock_gen clock_gen_inst (
        .clock  (clock),
        .arst_n (arst_n)
    );

    fir_filter fir_filter_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .cfg_req   (cfg_req),
        .cfg_rsp   (cfg_rsp),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // Model of the filter rule: clamp the tap count, sum the products, scale and wrap
    function automatic logic signed [DATA_WIDTH-1:0] reference_output(
        input logic signed [DATA_WIDTH-1:0] sample
    );
        longint sum;
        longint scaled;
        int     count;
        for (int i = MAX_N_TAPS - 1; i > 0; i--) begin
            model_delay[i] = model_delay[i-1];
        end
        model_delay[0] = sample;
        if (model_n_taps == 32'd0) begin
            count = 1;
        end else if (model_n_taps > MAX_N_TAPS) begin
            count = MAX_N_TAPS;
        end else begin
            count = model_n_taps;
        end
        sum = 0;
        for (int i = 0; i < count; i++) begin
            sum += longint'(model_taps[i]) * longint'(model_delay[i]);
        end
        scaled = sum >>> TAP_FRAC;
        return scaled[DATA_WIDTH-1:0];
    endfunction

    task automatic abort_run(input string reason);
        $display("Timeout at %0t: %s", $time, reason);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic check_sample(input stream_beat_t actual, input stream_beat_t expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: out_beat got %0d (valid %0b) expected %0d (valid %0b)",
                     $time, actual.data, actual.valid, expected.data, expected.valid);
            error_count++;
        end
    endtask

    task automatic check_reg(input cfg_reg_e name, input logic [31:0] actual,
                             input logic [31:0] expected);
        string label;
        label = name.name();
        if (label == "") label = $sformatf("word %0d", name);
        if (actual !== expected) begin
            $display("Mismatch at %0t: register %s got 0x%08h expected 0x%08h",
                     $time, label, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_resp(input axil_resp_e actual, input axil_resp_e expected,
                              input string channel);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s got %b expected %s",
                     $time, channel, actual, expected.name());
            error_count++;
        end
    endtask

    task automatic write_register(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] offset;
        int          cycles;
        @(posedge clock);
        cfg_req.awaddr  <= addr;
        cfg_req.wdata   <= data;
        cfg_req.wstrb   <= 4'hF;
        cfg_req.awvalid <= 1'b1;
        cfg_req.wvalid  <= 1'b1;
        cfg_req.bready  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("write address and data never accepted");
        end while (!(cfg_rsp.awready && cfg_rsp.wready));
        cfg_req.awvalid <= 1'b0;
        cfg_req.wvalid  <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("write response never arrived");
        end while (!cfg_rsp.bvalid);
        check_resp(cfg_rsp.bresp, OKAY, "bresp");
        cfg_req.bready <= 1'b0;
        // A tap address write copies the tap data register into that slot
        offset = addr & `FIR_ADDR_MASK;
        if (offset == 32'h0) begin
            model_n_taps = data;
        end else if (offset == 32'h4) begin
            model_tap_data = data;
        end else if (offset == 32'h8) begin
            model_taps[data % MAX_N_TAPS] = model_tap_data[TAP_WIDTH-1:0];
        end
    endtask

    task automatic read_and_check(input logic [31:0] addr, input logic [31:0] expected);
        logic [31:0] offset;
        int          cycles;
        offset = addr & `FIR_ADDR_MASK;
        @(posedge clock);
        cfg_req.araddr  <= addr;
        cfg_req.arvalid <= 1'b1;
        cfg_req.rready  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("read address never accepted");
        end while (!cfg_rsp.arready);
        cfg_req.arvalid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("read data never arrived");
        end while (!cfg_rsp.rvalid);
        check_reg(cfg_reg_e'(offset[7:2]), cfg_rsp.rdata, expected);
        check_resp(cfg_rsp.rresp, OKAY, "rresp");
        cfg_req.rready <= 1'b0;
    endtask

    task automatic send_sample(input logic signed [DATA_WIDTH-1:0] sample,
                               input logic signed [DATA_WIDTH-1:0] expected);
        stream_beat_t beat;
        int           cycles;
        beat.data  = expected;
        beat.valid = 1'b1;
        expected_q.push_back(beat);
        sent_count++;
        @(posedge clock);
        in_beat.data  <= sample;
        in_beat.valid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("input sample never accepted");
        end while (!in_ready);
        in_beat.valid <= 1'b0;
    endtask

    task automatic send_random_block(input int count);
        logic signed [DATA_WIDTH-1:0] sample;
        for (int i = 0; i < count; i++) begin
            sample = $random(seed);
            send_sample(sample, reference_output(sample));
        end
    endtask

    // A magnitude of zero selects the full coefficient range
    task automatic load_random_taps(input int magnitude);
        int value;
        for (int i = 0; i < MAX_N_TAPS; i++) begin
            value = (magnitude > 0) ? $random(seed) % magnitude : $random(seed);
            write_register(32'h4, value);
            write_register(32'h8, i);
        end
    endtask

    // Done once every expected sample is out and the core is back in IDLE
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 || !in_ready) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("expected outputs never drained");
        end
    endtask

    task automatic start_test();
        test_errors    = error_count;
        sent_count     = 0;
        received_count = 0;
    endtask

    task automatic finish_test(input string name);
        wait_drain();
        if (received_count != sent_count) begin
            $display("%0d samples were sent but %0d came out", sent_count, received_count);
            error_count++;
        end
        test_count++;
        if (error_count == test_errors) begin
            $display("Test %0d %s: PASS", test_count, name);
        end else begin
            $display("Test %0d %s: FAIL", test_count, name);
            failed_tests++;
        end
    endtask

    // Outputs are checked in order as each one transfers
    always @(posedge clock) begin
        if (arst_n && out_beat.valid && out_ready) begin
            received_count++;
            if (expected_q.size() == 0) begin
                $display("Output %0d at %0t arrived with no sample expected",
                         out_beat.data, $time);
                error_count++;
            end else begin
                expected_beat = expected_q.pop_front();
                check_sample(out_beat, expected_beat);
            end
        end
    end

    always @(posedge clock) begin
        out_ready <= bp_enable ? ready_pattern[bp_cycle] : 1'b1;
        bp_cycle  <= bp_cycle + 1'b1;
    end

    initial begin
        int cycles;
        logic signed [DATA_WIDTH-1:0] sample;
        cfg_req   = '0;
        in_beat   = '0;
        out_ready = 1'b0;
        bp_enable = 1'b0;
        bp_cycle  = '0;
        seed      = 32'h6d1f_4c4d;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        model_n_taps   = 32'd1;
        model_tap_data = '0;
        for (int i = 0; i < MAX_N_TAPS; i++) begin
            model_taps[i]  = '0;
            model_delay[i] = '0;
        end
        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("reset never released");
        end

        start_test();
        read_and_check(32'h0, 32'd1);
        read_and_check(32'h4, 32'd0);
        read_and_check(32'h8, 32'd0);
        write_register(32'h0, 32'd5);
        write_register(32'h4, 32'hA5A5_1234);
        write_register(32'h8, 32'd6);
        read_and_check(32'h0, 32'd5);
        read_and_check(32'h4, 32'hA5A5_1234);
        read_and_check(32'h8, 32'd6);
        write_register(32'h40, 32'hDEAD_BEEF);
        read_and_check(32'h40, 32'd0);
        // The unmapped write must leave every mapped register as it was
        read_and_check(32'h0, 32'd5);
        read_and_check(32'h4, 32'hA5A5_1234);
        read_and_check(32'h8, 32'd6);
        finish_test("register readback");

        // Each output is the negated tap, since the impulse is negative full scale
        start_test();
        load_random_taps(16000);
        write_register(32'h0, 32'd8);
        for (int k = 0; k < MAX_N_TAPS; k++) begin
            sample = (k == 0) ? IMPULSE : '0;
            void'(reference_output(sample));
            send_sample(sample, -model_taps[k]);
        end
        finish_test("impulse response");

        start_test();
        load_random_taps(0);
        send_random_block(64);
        finish_test("random stream");

        start_test();
        write_register(32'h0, 32'd3);
        send_random_block(16);
        wait_drain();
        write_register(32'h0, 32'd0);
        send_random_block(16);
        wait_drain();
        write_register(32'h0, 32'd12);
        send_random_block(16);
        finish_test("tap count clamp");

        start_test();
        for (int w = 0; w < 16; w++) begin
            ready_pattern[32*w +: 32] = $random(seed);
        end
        bp_enable = 1'b1;
        send_random_block(48);
        finish_test("back-pressure");
        bp_enable = 1'b0;

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+common
common/fir_pkg.sv
rtl/axil_register_cu.sv
fir/fir_tap_memory.sv
fir/fir_filter_serial.sv
rtl/fir_filter.sv
test/tb_clock_gen.sv
test/fir_filter_tb.sv

/* Bender.yml */
package:
  name: fir_filter

sources:
  - include_dirs:
      - common
    files:
      - common/fir_pkg.sv
      - rtl/axil_register_cu.sv
      - fir/fir_tap_memory.sv
      - fir/fir_filter_serial.sv
      - rtl/fir_filter.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_clock_gen.sv
      - test/fir_filter_tb.sv
